//--- common/raster_pkg.sv
// Signed fixed-point coordinates with RADIX fraction bits; colors are unsigned channels
// Only the four one-hot MSAA codes are legal, any other code gives a meaningless step

package raster_pkg;

    // Fixed-point format shared by coordinates and colors
    localparam int SIGFIG = 24;
    localparam int RADIX  = 10;

    // Triangle shape
    localparam int VERTS  = 3;
    localparam int AXIS   = 3;
    localparam int COLORS = 3;

    typedef logic signed [SIGFIG-1:0] coord_t;
    typedef logic [SIGFIG-1:0]        chan_t;

    // One-hot code, 1000 is 1x and 0001 is 64x
    typedef logic [3:0] msaa_t;

    // Vertex index first, then x/y/z
    typedef struct packed {
        coord_t [VERTS-1:0][AXIS-1:0] vert;
        chan_t [COLORS-1:0]           color;
    } tri_t;

    typedef struct packed {
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
    } box_t;

    // Unit accepted from upstream
    typedef struct packed {
        tri_t  prim;
        box_t  box;
        msaa_t msaa;
    } job_t;

    // Unit sent to the sample-test stage
    typedef struct packed {
        tri_t   prim;
        coord_t x;
        coord_t y;
    } sample_t;

    // Sample spacing, 1000 gives one pixel and 0001 an eighth of a pixel
    function automatic coord_t step_size(input msaa_t code);
        coord_t step;
        step = coord_t'(code);
        return step << (RADIX - 3);
    endfunction

endpackage

//--- src/tri_slot.sv
// Single-entry job buffer; upstream may only send while it holds the one credit
// A job_valid into a full slot is not expected and overwrites the held job

`timescale 1ns/1ps

module tri_slot
    import raster_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // Upstream side
    input  logic job_valid,
    input  job_t job,
    output logic job_credit,

    // Walker side
    input  logic take,
    output logic slot_full,
    output job_t slot_job
);

    // Occupancy and credit return
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_full  <= 1'b0;
            job_credit <= 1'b0;
        end else begin
            // Credit goes back one cycle after the walker empties the slot
            job_credit <= take && slot_full;

            if (take) begin
                slot_full <= 1'b0;
            end
            // New job lands the cycle after job_valid
            if (job_valid) begin
                slot_full <= 1'b1;
            end
        end
    end

    // Held triangle, box and MSAA code
    always_ff @(posedge clk) begin
        if (job_valid) begin
            slot_job <= job;
        end
    end

endmodule

//--- iterator/bbox_walker.sv
// Walks the box bottom-up, left to right, from the lower-left corner in MSAA steps
// Box max must be at or above box min, otherwise the walk ends after the first row edge

`timescale 1ns/1ps

module bbox_walker
    import raster_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // From the triangle slot
    input  logic    slot_full,
    input  job_t    slot_job,
    output logic    take,

    // To the sample register
    input  logic    can_send,
    output logic    emit,
    output sample_t emit_sample
);

    typedef enum logic {
        WAIT_JOB,
        WALK
    } state_t;

    state_t state;

    // Current job, latched on take
    tri_t   prim_q;
    box_t   box_q;
    coord_t step_q;

    // Current sample position
    coord_t x_q;
    coord_t y_q;

    logic at_right;
    logic at_top;

    // Edge tests on the current position
    assign at_right = x_q >= box_q.max_x;
    assign at_top   = y_q >= box_q.max_y;

    // Only pull a job when idle
    assign take = (state == WAIT_JOB) && slot_full;

    // One sample per cycle while downstream has room
    assign emit = (state == WALK) && can_send;

    assign emit_sample = '{prim: prim_q, x: x_q, y: y_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT_JOB;
        end else begin
            case (state)
                WAIT_JOB: begin
                    if (take) begin
                        state <= WALK;
                    end
                end
                WALK: begin
                    // Top-right sample sent, job done
                    if (emit && at_right && at_top) begin
                        state <= WAIT_JOB;
                    end
                end
                default: begin
                    state <= WAIT_JOB;
                end
            endcase
        end
    end

    // Position moves only on emit, so a stall holds the sample
    always_ff @(posedge clk) begin
        if (take) begin
            prim_q <= slot_job.prim;
            box_q  <= slot_job.box;
            step_q <= step_size(slot_job.msaa);
            // Start at lower-left corner
            x_q    <= slot_job.box.min_x;
            y_q    <= slot_job.box.min_y;
        end else if (emit) begin
            if (at_right) begin
                // Wrap to the next row
                x_q <= box_q.min_x;
                y_q <= y_q + step_q;
            end else begin
                x_q <= x_q + step_q;
            end
        end
    end

endmodule

//--- src/sample_out.sv
// Output register toward sample test with a downstream credit count
// Downstream must never return more credits than OUT_CREDITS in total outstanding

`timescale 1ns/1ps

module sample_out
    import raster_pkg::*;
#(
    parameter int unsigned OUT_CREDITS = 4
)
(
    input  logic    clk,
    input  logic    rst,

    // From the walker
    input  logic    emit,
    input  sample_t emit_sample,
    output logic    can_send,

    // Downstream side
    input  logic    samp_credit,
    output logic    samp_valid,
    output sample_t samp
);

    // Wide enough to hold the full credit count
    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0] credit_cnt;

    // Walker may emit while any credit is left
    assign can_send = credit_cnt != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CW'(OUT_CREDITS);
            samp_valid <= 1'b0;
        end else begin
            samp_valid <= emit;

            // Spend on emit so the count is already down when samp_valid shows
            case ({emit, samp_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Sample payload
    always_ff @(posedge clk) begin
        if (emit) begin
            samp <= emit_sample;
        end
    end

endmodule

//--- src/sample_iterator_top.sv
// Triangle slot, box walker and sample register with a credit loop on each side
// Upstream starts with one job credit and downstream with OUT_CREDITS sample credits

`timescale 1ns/1ps

module sample_iterator_top
    import raster_pkg::*;
#(
    parameter int unsigned OUT_CREDITS = 4
)
(
    input  logic    clk,
    input  logic    rst,

    // Triangle jobs in
    input  logic    job_valid,
    input  job_t    job,
    output logic    job_credit,

    // Samples out
    output logic    samp_valid,
    output sample_t samp,
    input  logic    samp_credit
);

    // Slot to walker
    logic    slot_full;
    job_t    slot_job;
    logic    take;

    // Walker to output register
    logic    can_send;
    logic    emit;
    sample_t emit_sample;

    tri_slot u_slot (
        .clk        (clk),
        .rst        (rst),
        .job_valid  (job_valid),
        .job        (job),
        .job_credit (job_credit),
        .take       (take),
        .slot_full  (slot_full),
        .slot_job   (slot_job)
    );

    bbox_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .slot_full   (slot_full),
        .slot_job    (slot_job),
        .take        (take),
        .can_send    (can_send),
        .emit        (emit),
        .emit_sample (emit_sample)
    );

    sample_out #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_out (
        .clk         (clk),
        .rst         (rst),
        .emit        (emit),
        .emit_sample (emit_sample),
        .can_send    (can_send),
        .samp_credit (samp_credit),
        .samp_valid  (samp_valid),
        .samp        (samp)
    );

endmodule

//--- sim/tb_sample_iterator.sv
// Run from the project root so sim/testdata_iterator.txt is found
// Upstream holds one job credit, downstream returns sample credits after random delays

`timescale 1ns/1ps

module tb_sample_iterator;
    import raster_pkg::*;

    localparam int OUT_CREDITS = 4;
    localparam int NUM_TESTS   = 9;
    localparam int WORDS       = 20;
    localparam int MAX_DELAY   = 16;

    logic    clk;
    logic    rst;
    logic    job_valid;
    job_t    job;
    logic    job_credit;
    logic    samp_valid;
    sample_t samp;
    logic    samp_credit = 1'b0;

    // One line per triangle, WORDS hex values each
    logic [SIGFIG-1:0] tdata [0:NUM_TESTS*WORDS-1];

    integer seed = 60;
    int hold;
    int received;
    int returned;
    int credits_seen;
    int jc_seen;
    int jobs_sent;
    int errors;
    int mon_errors;
    int failed;
    int total_expected;
    int cycles;
    int timeout_limit = 100000;

    sample_iterator_top #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .job_valid   (job_valid),
        .job         (job),
        .job_credit  (job_credit),
        .samp_valid  (samp_valid),
        .samp        (samp),
        .samp_credit (samp_credit)
    );

    always #10 clk = ~clk;

    function automatic logic [SIGFIG-1:0] field_of(input int t, input int i);
        return tdata[t*WORDS + i];
    endfunction

    // Columns: msaa, box, 3x3 vertex coords, 3 colors, count, last x, last y
    function automatic job_t job_from_data(input int t);
        job_t              j;
        logic [SIGFIG-1:0] w;
        w           = field_of(t, 0);
        j.msaa      = w[3:0];
        j.box.min_x = field_of(t, 1);
        j.box.min_y = field_of(t, 2);
        j.box.max_x = field_of(t, 3);
        j.box.max_y = field_of(t, 4);
        for (int v = 0; v < VERTS; v++) begin
            for (int a = 0; a < AXIS; a++) begin
                j.prim.vert[v][a] = field_of(t, 5 + v*AXIS + a);
            end
        end
        for (int c = 0; c < COLORS; c++) begin
            j.prim.color[c] = field_of(t, 14 + c);
        end
        return j;
    endfunction

    // One pixel is 1 << RADIX, each finer code halves the spacing
    function automatic coord_t step_of(input msaa_t code);
        case (code)
            4'b1000: return coord_t'(1 << RADIX);
            4'b0100: return coord_t'(1 << (RADIX - 1));
            4'b0010: return coord_t'(1 << (RADIX - 2));
            default: return coord_t'(1 << (RADIX - 3));
        endcase
    endfunction

    // Downstream partner, returns one credit per received sample after a random wait
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            samp_credit <= 1'b0;
            hold        <= 0;
            returned    <= 0;
        end else begin
            samp_credit <= 1'b0;
            if (hold != 0) begin
                hold <= hold - 1;
            end else if (received > returned) begin
                samp_credit <= 1'b1;
                returned    <= returned + 1;
                hold        <= {$random(seed)} % (MAX_DELAY + 1);
            end
        end
    end

    // Pulse counters, plus the outstanding sample bound
    always @(negedge clk) begin
        if (!rst) begin
            if (samp_valid) begin
                assert (received < OUT_CREDITS + credits_seen) else begin
                    $display("Sample sent without a credit: %0d samples, %0d credits granted",
                             received + 1, OUT_CREDITS + credits_seen);
                    mon_errors <= mon_errors + 1;
                end
                received <= received + 1;
            end
            if (samp_credit) begin
                credits_seen <= credits_seen + 1;
            end
            if (job_credit) begin
                jc_seen <= jc_seen + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles with %0d samples received", cycles, received);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Follows the walk rule and compares every sample of job t
    task automatic check_job(input int t);
        job_t   j;
        coord_t step;
        coord_t min_x;
        coord_t max_x;
        coord_t max_y;
        coord_t ex;
        coord_t ey;
        coord_t last_x;
        coord_t last_y;
        int     n;
        int     err0;
        logic   done;
        j      = job_from_data(t);
        step   = step_of(j.msaa);
        min_x  = j.box.min_x;
        max_x  = j.box.max_x;
        max_y  = j.box.max_y;
        ex     = min_x;
        ey     = j.box.min_y;
        last_x = '0;
        last_y = '0;
        n      = 0;
        err0   = errors;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (samp_valid) begin
                assert (samp.x == ex) else begin
                    $display("Mismatch test %0d sample %0d samp.x: expected %h got %h",
                             t, n, ex, samp.x);
                    errors++;
                end
                assert (samp.y == ey) else begin
                    $display("Mismatch test %0d sample %0d samp.y: expected %h got %h",
                             t, n, ey, samp.y);
                    errors++;
                end
                assert (samp.prim.vert == j.prim.vert) else begin
                    $display("Mismatch test %0d sample %0d samp.prim.vert: expected %h got %h",
                             t, n, j.prim.vert, samp.prim.vert);
                    errors++;
                end
                assert (samp.prim.color == j.prim.color) else begin
                    $display("Mismatch test %0d sample %0d samp.prim.color: expected %h got %h",
                             t, n, j.prim.color, samp.prim.color);
                    errors++;
                end
                last_x = samp.x;
                last_y = samp.y;
                n++;
                // Job ends on the sample at or past the top-right corner
                done = (samp.x >= max_x) && (samp.y >= max_y);
                // Next expected position, right then up
                if (ex >= max_x) begin
                    ex = min_x;
                    ey = ey + step;
                end else begin
                    ex = ex + step;
                end
            end
        end
        assert (n == int'(field_of(t, 17))) else begin
            $display("Mismatch test %0d sample count: expected %h got %h",
                     t, field_of(t, 17), n);
            errors++;
        end
        assert (last_x == coord_t'(field_of(t, 18))) else begin
            $display("Mismatch test %0d last samp.x: expected %h got %h",
                     t, field_of(t, 18), last_x);
            errors++;
        end
        assert (last_y == coord_t'(field_of(t, 19))) else begin
            $display("Mismatch test %0d last samp.y: expected %h got %h",
                     t, field_of(t, 19), last_y);
            errors++;
        end
        if (errors == err0) begin
            $display("Test %0d msaa %b: %0d samples ok", t, j.msaa, n);
        end else begin
            $display("Test %0d msaa %b: %0d samples, %0d errors", t, j.msaa, n, errors - err0);
            failed++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        job_valid = 1'b0;
        job       = '0;
        $readmemh("sim/testdata_iterator.txt", tdata);
        for (int i = 0; i < NUM_TESTS; i++) begin
            total_expected += int'(field_of(i, 17));
        end
        // Worst case one credit back per MAX_DELAY + 1 cycles
        timeout_limit = total_expected * (MAX_DELAY + 2) + 200;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Nothing may move without a job
        repeat (10) begin
            @(negedge clk);
            assert (!samp_valid) else begin
                $display("Mismatch idle samp_valid: expected 0 got %h", samp_valid);
                errors++;
            end
            assert (!job_credit) else begin
                $display("Mismatch idle job_credit: expected 0 got %h", job_credit);
                errors++;
            end
        end

        fork
            // Upstream sends as soon as its single credit is back
            begin
                for (int t = 0; t < NUM_TESTS; t++) begin
                    while (1 + jc_seen - jobs_sent <= 0) @(negedge clk);
                    @(posedge clk);
                    job_valid <= 1'b1;
                    job       <= job_from_data(t);
                    jobs_sent++;
                    @(posedge clk);
                    job_valid <= 1'b0;
                end
            end
            begin
                for (int t = 0; t < NUM_TESTS; t++) begin
                    check_job(t);
                end
            end
        join

        // Let stray samples or credits show up
        repeat (20) @(negedge clk);
        assert (jc_seen == jobs_sent) else begin
            $display("Mismatch job_credit pulses: expected %h got %h", jobs_sent, jc_seen);
            errors++;
        end
        assert (received == total_expected) else begin
            $display("Mismatch samp_valid pulses: expected %h got %h", total_expected, received);
            errors++;
        end

        $display("Tests %0d, failed %0d, samples %0d, errors %0d",
                 NUM_TESTS, failed, received, errors + mon_errors);
        if (failed == 0 && errors + mon_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim/testdata_iterator.txt
// msaa minx miny maxx maxy | v0 x y z | v1 x y z | v2 x y z | c0 c1 c2 | count lastx lasty
// All hex, 24-bit two's complement coordinates with 10 fraction bits
8 0 0 C00 800 0 0 100 C00 0 100 600 800 100 FF0000 FF00 FF C C00 800
4 400 400 800 600 400 400 200 800 400 200 800 600 200 123456 654321 ABCDEF 6 800 600
2 1000 2000 1300 2100 1000 2000 300 1300 2000 300 1000 2100 300 800000 400000 200000 8 1300 2100
1 0 0 180 100 0 0 0 180 0 0 0 100 0 111111 222222 333333 C 180 100
8 FFF800 FFFC00 0 400 FFF800 FFFC00 400 0 FFFC00 400 FFFC00 400 400 AA BB00 CC0000 9 0 400
8 0 0 500 100 0 0 7 500 0 7 0 100 7 0F0F0F F0F0F0 5A5A5A 6 800 400
4 600 600 600 600 600 600 1 600 600 1 600 600 1 FFFFFF 0 FFFFFF 1 600 600
2 200 0 200 300 200 0 2 200 300 2 200 0 2 13579B 2468AC 0 4 200 300
1 FFFF00 FFFF80 0 0 FFFF00 FFFF80 10 0 FFFF80 10 FFFF00 0 10 7 8 9 6 0 0

//--- flist.f
common/raster_pkg.sv
src/tri_slot.sv
iterator/bbox_walker.sv
src/sample_out.sv
src/sample_iterator_top.sv
sim/tb_sample_iterator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the sample iterator testbench
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module tb_sample_iterator -f flist.f -o tb_sample_iterator

./obj_dir/tb_sample_iterator > sim.log 2>&1
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
    exit 1
fi
if ! grep -qF "*** PASSED ***" sim.log; then
    exit 1
fi
